/* hw/credit_link_pkg.sv */
/*
  Sizes shared by every block of the credit link.
  Credits per lane equal the lane FIFO depth, so max_credit sets both.
  The derived widths assume num_lanes and max_credit are powers of two.
*/

package credit_link_pkg;

  // ------------------------------------------------------------
  // Link geometry
  // ------------------------------------------------------------

  // Number of independent credit lanes behind the single sender.
  localparam int num_lanes = 4;

  // Width of a lane index carried on in_lane and out_lane.
  localparam int lane_w = $clog2(num_lanes);

  // Width of one link word.
  localparam int data_w = 16;

  // ------------------------------------------------------------
  // Credit and buffer sizing
  // ------------------------------------------------------------

  // Credits per lane.
  // Each credit stands for one free FIFO slot in that lane.
  localparam int max_credit = 4;

  // A counter must hold every value from 0 up to max_credit inclusive.
  localparam int cnt_w = $clog2(max_credit + 1);

  // Read and write pointers index the max_credit FIFO slots.
  localparam int ptr_w = $clog2(max_credit);

endpackage

/* hw/credit_sender.sv */
/*
  Ingress side of the credit link, with one credit counter per lane.
  The ingress port is a four-phase req/ack handshake, one word per transfer.
  A word is forwarded only while its lane holds a credit, else in_ack stalls.
  link_hold must only be raised while every lane buffer is empty.
*/

module credit_sender (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_req,
  output logic                                   in_ack,
  input  logic [credit_link_pkg::lane_w-1:0]     in_lane,
  input  logic [credit_link_pkg::data_w-1:0]     in_data,
  input  logic                                   link_hold,
  input  logic [credit_link_pkg::num_lanes-1:0]  push_credit,
  input  logic [credit_link_pkg::num_lanes-1:0]  reset_active_rev,
  output logic [credit_link_pkg::num_lanes-1:0]  push_valid,
  output logic [credit_link_pkg::data_w-1:0]     push_data,
  output logic                                   reset_active_fwd
);

  // Credits currently held for each lane.
  logic [credit_link_pkg::cnt_w-1:0] credit_cnt [credit_link_pkg::num_lanes];

  // Registered copy of link_hold, also set while rst_n is low.
  logic fwd_q;

  // The pending ingress word may be taken on this edge.
  logic accept;

  // One-hot lane that spends a credit on this edge.
  logic [credit_link_pkg::num_lanes-1:0] take;

  // ------------------------------------------------------------
  // Reset handshake toward the receivers
  // ------------------------------------------------------------

  // The forward reset rises together with link_hold and falls one cycle
  // after it. Out of rst_n it stays high for one more cycle as well.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fwd_q <= 1'b1;
    end else begin
      fwd_q <= link_hold;
    end
  end

  assign reset_active_fwd = link_hold | fwd_q;

  // ------------------------------------------------------------
  // Ingress acceptance and lane steering
  // ------------------------------------------------------------

  // A word is taken only in the idle phase of the handshake, for a lane
  // that holds a credit and whose receiver has left reset.
  assign accept = in_req && !in_ack && !reset_active_fwd &&
                  !reset_active_rev[in_lane] && (credit_cnt[in_lane] != '0);

  always_comb begin
    for (int i = 0; i < credit_link_pkg::num_lanes; i++) begin
      take[i] = accept && (in_lane == credit_link_pkg::lane_w'(i));
    end
  end

  // The ack rises with the push pulse and holds until in_req drops.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack     <= 1'b0;
      push_valid <= '0;
    end else begin
      push_valid <= take;
      if (accept) begin
        in_ack <= 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
    end
  end

  // Payload register, shared by all lanes.
  // Only the lane named by push_valid looks at it.
  always_ff @(posedge clk) begin
    if (accept) begin
      push_data <= in_data;
    end
  end

  // ------------------------------------------------------------
  // Per-lane credit counters
  // ------------------------------------------------------------

  // A received credit shows up in the count one cycle later.
  // Either side of the reset handshake empties the count.
  // The receiver then hands out its initial credits again.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < credit_link_pkg::num_lanes; i++) begin
        credit_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < credit_link_pkg::num_lanes; i++) begin
        if (reset_active_fwd || reset_active_rev[i]) begin
          credit_cnt[i] <= '0;
        end else begin
          credit_cnt[i] <= credit_cnt[i] + credit_link_pkg::cnt_w'(push_credit[i]) -
                           credit_link_pkg::cnt_w'(take[i]);
        end
      end
    end
  end

endmodule

/* hw/credit_receiver.sv */
/*
  Receiver side of one credit lane.
  The count starts at max_credit and is handed to the sender one per cycle.
  The data path is not routed through here, the lane FIFO holds the words.
  A withhold larger than the count simply releases nothing.
*/

module credit_receiver (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               reset_active_fwd,
  output logic                               reset_active_rev,
  output logic                               push_credit,
  input  logic                               pop_credit,
  input  logic [credit_link_pkg::cnt_w-1:0]  credit_withhold
);

  // Credits still held here, not yet released to the sender.
  logic [credit_link_pkg::cnt_w-1:0] credit_count;

  // Part of the count that may be released right now.
  logic [credit_link_pkg::cnt_w-1:0] credit_available;

  // ------------------------------------------------------------
  // Reverse reset indication
  // ------------------------------------------------------------

  // High while rst_n is low and for the first cycle after it.
  // The sender keeps its count for this lane at zero meanwhile.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_active_rev <= 1'b1;
    end else begin
      reset_active_rev <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Credit release
  // ------------------------------------------------------------

  // Withheld credits stay in the count but are not offered.
  // The difference is clamped so a large withhold cannot wrap.
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

  // Release is combinational, one credit per cycle at most.
  // Nothing goes out while either side of the link is in reset.
  assign push_credit = (credit_available != '0) && !reset_active_fwd && !reset_active_rev;

  // ------------------------------------------------------------
  // Credit counter
  // ------------------------------------------------------------

  // A pop returns a credit in the same cycle a release may take one.
  // Both can happen at once and then the count is unchanged.
  // A forward reset reloads the full amount; the link is empty then.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= credit_link_pkg::cnt_w'(credit_link_pkg::max_credit);
    end else if (reset_active_fwd) begin
      credit_count <= credit_link_pkg::cnt_w'(credit_link_pkg::max_credit);
    end else begin
      credit_count <= credit_count + credit_link_pkg::cnt_w'(pop_credit) -
                      credit_link_pkg::cnt_w'(push_credit);
    end
  end

endmodule

/* hw/credit_lane.sv */
/*
  One lane of the link, a credit receiver plus the FIFO it manages.
  The FIFO has max_credit slots and never overflows under the credit rule.
  A written word shows on lane_valid and lane_data on the next cycle.
*/

module credit_lane (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               reset_active_fwd,
  output logic                               reset_active_rev,
  output logic                               push_credit,
  input  logic                               push_valid,
  input  logic [credit_link_pkg::data_w-1:0] push_data,
  input  logic                               lane_pop,
  output logic                               lane_valid,
  output logic [credit_link_pkg::data_w-1:0] lane_data,
  input  logic [credit_link_pkg::cnt_w-1:0]  credit_withhold
);

  // Storage for the words in flight on this lane.
  logic [credit_link_pkg::data_w-1:0] mem [credit_link_pkg::max_credit];

  logic [credit_link_pkg::ptr_w-1:0] wr_ptr;
  logic [credit_link_pkg::ptr_w-1:0] rd_ptr;

  // Number of words held, 0 up to max_credit.
  logic [credit_link_pkg::cnt_w-1:0] occupancy;

  // ------------------------------------------------------------
  // Credit management
  // ------------------------------------------------------------

  // Every pop frees a slot, and that slot goes back as a credit.
  // Credits in circulation therefore always match the free slots.
  credit_receiver u_receiver (
    .clk              (clk),
    .rst_n            (rst_n),
    .reset_active_fwd (reset_active_fwd),
    .reset_active_rev (reset_active_rev),
    .push_credit      (push_credit),
    .pop_credit       (lane_pop),
    .credit_withhold  (credit_withhold)
  );

  // ------------------------------------------------------------
  // FIFO buffer
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push_valid) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at the last slot.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (push_valid) begin
        if (wr_ptr == credit_link_pkg::ptr_w'(credit_link_pkg::max_credit - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + credit_link_pkg::ptr_w'(1);
        end
      end
      if (lane_pop) begin
        if (rd_ptr == credit_link_pkg::ptr_w'(credit_link_pkg::max_credit - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + credit_link_pkg::ptr_w'(1);
        end
      end
      occupancy <= occupancy + credit_link_pkg::cnt_w'(push_valid) -
                   credit_link_pkg::cnt_w'(lane_pop);
    end
  end

  // The head word is read straight from the array.
  assign lane_valid = (occupancy != '0);
  assign lane_data  = mem[rd_ptr];

endmodule

/* hw/egress_arbiter.sv */
/*
  Round-robin drain of the lane FIFOs onto the four-phase egress port.
  The winner is held for the whole req/ack transfer.
  The head is popped only after out_ack has been seen high.
*/

module egress_arbiter (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [credit_link_pkg::num_lanes-1:0]                 lane_valid,
  input  logic [credit_link_pkg::num_lanes*credit_link_pkg::data_w-1:0] lane_data,
  output logic [credit_link_pkg::num_lanes-1:0]                 lane_pop,
  output logic                                                  out_req,
  input  logic                                                  out_ack,
  output logic [credit_link_pkg::lane_w-1:0]                    out_lane,
  output logic [credit_link_pkg::data_w-1:0]                    out_data
);

  // Lane served by the last completed transfer.
  logic [credit_link_pkg::lane_w-1:0] last_lane;

  // Waiting for out_ack to drop after a transfer.
  logic drain;

  // Result of the round-robin search.
  logic                               found;
  logic [credit_link_pkg::lane_w-1:0] pick;

  // A new transfer starts on this edge.
  logic grant;

  // ------------------------------------------------------------
  // Round-robin search
  // ------------------------------------------------------------

  // Scan from the lane after last_lane and wrap at num_lanes.
  // The first lane with data wins.
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = last_lane;
    for (int k = 1; k <= credit_link_pkg::num_lanes; k++) begin
      idx = (int'(last_lane) + k) % credit_link_pkg::num_lanes;
      if (!found && lane_valid[idx]) begin
        found = 1'b1;
        pick  = credit_link_pkg::lane_w'(idx);
      end
    end
  end

  // Idle means no request up and no ack still to clear.
  assign grant = found && !out_req && !drain;

  // ------------------------------------------------------------
  // Egress handshake
  // ------------------------------------------------------------

  // out_req rises one cycle after a grant and falls with the pop pulse.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_req   <= 1'b0;
      out_lane  <= '0;
      drain     <= 1'b0;
      last_lane <= credit_link_pkg::lane_w'(credit_link_pkg::num_lanes - 1);
      lane_pop  <= '0;
    end else begin
      for (int i = 0; i < credit_link_pkg::num_lanes; i++) begin
        lane_pop[i] <= out_req && out_ack && (out_lane == credit_link_pkg::lane_w'(i));
      end
      if (grant) begin
        out_req  <= 1'b1;
        out_lane <= pick;
      end else if (out_req && out_ack) begin
        out_req   <= 1'b0;
        drain     <= 1'b1;
        last_lane <= out_lane;
      end else if (drain && !out_ack) begin
        drain <= 1'b0;
      end
    end
  end

  // The head word is captured with the grant and stays stable on out_data.
  always_ff @(posedge clk) begin
    if (grant) begin
      out_data <= lane_data[int'(pick)*credit_link_pkg::data_w +: credit_link_pkg::data_w];
    end
  end

endmodule

/* hw/credit_link_top.sv */
/*
  Multi-lane credit link, from one ingress port to one egress port.
  All lanes share clk, rst_n, link_hold and the same credit_withhold.
  Raise link_hold only while every lane buffer is empty.
*/

module credit_link_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [credit_link_pkg::cnt_w-1:0]  credit_withhold,
  input  logic                               link_hold,
  input  logic                               in_req,
  output logic                               in_ack,
  input  logic [credit_link_pkg::lane_w-1:0] in_lane,
  input  logic [credit_link_pkg::data_w-1:0] in_data,
  output logic                               out_req,
  input  logic                               out_ack,
  output logic [credit_link_pkg::lane_w-1:0] out_lane,
  output logic [credit_link_pkg::data_w-1:0] out_data
);

  // Link between sender and lanes, one bit or slice per lane.
  logic [credit_link_pkg::num_lanes-1:0] push_valid;
  logic [credit_link_pkg::num_lanes-1:0] push_credit;
  logic [credit_link_pkg::num_lanes-1:0] reset_active_rev;
  logic [credit_link_pkg::data_w-1:0]    push_data;
  logic                                  reset_active_fwd;

  // Pop side between lanes and arbiter.
  logic [credit_link_pkg::num_lanes-1:0]                         lane_valid;
  logic [credit_link_pkg::num_lanes-1:0]                         lane_pop;
  logic [credit_link_pkg::num_lanes*credit_link_pkg::data_w-1:0] lane_data;

  credit_sender u_sender (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_req           (in_req),
    .in_ack           (in_ack),
    .in_lane          (in_lane),
    .in_data          (in_data),
    .link_hold        (link_hold),
    .push_credit      (push_credit),
    .reset_active_rev (reset_active_rev),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .reset_active_fwd (reset_active_fwd)
  );

  // Lane g owns bit g of each vector and slice g of lane_data.
  for (genvar g = 0; g < credit_link_pkg::num_lanes; g++) begin : gen_lane
    credit_lane u_lane (
      .clk              (clk),
      .rst_n            (rst_n),
      .reset_active_fwd (reset_active_fwd),
      .reset_active_rev (reset_active_rev[g]),
      .push_credit      (push_credit[g]),
      .push_valid       (push_valid[g]),
      .push_data        (push_data),
      .lane_pop         (lane_pop[g]),
      .lane_valid       (lane_valid[g]),
      .lane_data        (lane_data[g*credit_link_pkg::data_w +: credit_link_pkg::data_w]),
      .credit_withhold  (credit_withhold)
    );
  end

  egress_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_valid (lane_valid),
    .lane_data  (lane_data),
    .lane_pop   (lane_pop),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_lane   (out_lane),
    .out_data   (out_data)
  );

endmodule

/* verification/tb_credit_link_tasks.svh */
/*
  Handshake drivers and directed tests that are included inside tb_credit_link.
  They use the testbench signals, queues and counters directly.
  Inputs change 1 time unit after a rising edge and outputs are read there too.
*/

// ------------------------------------------------------------
// Four-phase drivers
// ------------------------------------------------------------

// Offers one word at the ingress. A word that is acked goes into its lane queue.
task automatic send_word(input string test_name,
                         input logic [credit_link_pkg::lane_w-1:0] lane,
                         input logic [credit_link_pkg::data_w-1:0] data,
                         input logic expect_ack);
  int   waited;
  logic acked;
  @(posedge clk);
  #1;
  in_lane = lane;
  in_data = data;
  in_req  = 1'b1;
  acked   = 1'b0;
  waited  = 0;
  while (!acked && waited < ack_timeout) begin
    @(posedge clk);
    #1;
    waited++;
    acked = in_ack;
  end
  // Dropping in_req here also withdraws a word that was never taken.
  in_req = 1'b0;
  check_value(test_name, "in_ack seen", 32'(expect_ack), 32'(acked));
  if (acked) begin
    exp_q[lane].push_back(data);
    waited = 0;
    while (in_ack && waited < ack_timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (in_ack) begin
      timeout_count++;
      $display("Timeout in %s: in_ack stayed high after in_req fell", test_name);
    end
  end
endtask

// Takes one word at the egress and checks it against its lane queue.
task automatic take_word(input string test_name,
                         output logic [credit_link_pkg::lane_w-1:0] lane);
  int                                 waited;
  logic [credit_link_pkg::data_w-1:0] data;
  logic [credit_link_pkg::data_w-1:0] expected;
  lane   = '0;
  waited = 0;
  while (!out_req && waited < req_timeout) begin
    @(posedge clk);
    #1;
    waited++;
  end
  if (!out_req) begin
    timeout_count++;
    $display("Timeout in %s: the DUT never raised out_req", test_name);
  end else begin
    lane    = out_lane;
    data    = out_data;
    out_ack = 1'b1;
    waited  = 0;
    while (out_req && waited < req_timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    out_ack = 1'b0;
    if (out_req) begin
      timeout_count++;
      $display("Timeout in %s: out_req stayed high after out_ack", test_name);
    end
    check_count++;
    assert (exp_q[lane].size() > 0) else begin
      error_count++;
      $display("In %s lane %0d delivered a word that was never sent", test_name, lane);
    end
    if (exp_q[lane].size() > 0) begin
      expected = exp_q[lane].pop_front();
      check_value(test_name, "out_data", 32'(expected), 32'(data));
    end
  end
endtask

// Every accepted word must have left the link.
task automatic check_drained(input string test_name);
  for (int i = 0; i < credit_link_pkg::num_lanes; i++) begin
    check_value(test_name, "words left in lane queue", 32'd0, 32'(exp_q[i].size()));
  end
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------

// Random lanes and data with the egress taking words in parallel.
task automatic test_integrity();
  logic [credit_link_pkg::lane_w-1:0] got;
  logic [31:0]                        r;
  fork
    for (int n = 0; n < 32; n++) begin
      r = lcg_next();
      send_word("integrity", credit_link_pkg::lane_w'(r >> 16),
                credit_link_pkg::data_w'(r), 1'b1);
    end
    for (int n = 0; n < 32; n++) begin
      take_word("integrity", got);
    end
  join
  check_drained("integrity");
endtask

// With out_ack low each lane takes max_credit words and then stalls.
task automatic test_backpressure();
  logic [credit_link_pkg::lane_w-1:0] got;
  for (int l = 0; l < credit_link_pkg::num_lanes; l++) begin
    for (int n = 0; n < credit_link_pkg::max_credit; n++) begin
      send_word("backpressure", credit_link_pkg::lane_w'(l),
                credit_link_pkg::data_w'(lcg_next()), 1'b1);
    end
    send_word("backpressure", credit_link_pkg::lane_w'(l),
              credit_link_pkg::data_w'(lcg_next()), 1'b0);
  end
  for (int n = 0; n < credit_link_pkg::num_lanes * credit_link_pkg::max_credit; n++) begin
    take_word("backpressure", got);
  end
  check_drained("backpressure");
endtask

// A withhold of 2 leaves max_credit minus 2 usable slots on lanes 1 and 3.
task automatic test_withhold();
  logic [credit_link_pkg::lane_w-1:0] got;
  apply_reset(credit_link_pkg::cnt_w'(2));
  for (int l = 1; l < credit_link_pkg::num_lanes; l += 2) begin
    for (int n = 0; n < credit_link_pkg::max_credit - 2; n++) begin
      send_word("withhold", credit_link_pkg::lane_w'(l),
                credit_link_pkg::data_w'(lcg_next()), 1'b1);
    end
    send_word("withhold", credit_link_pkg::lane_w'(l),
              credit_link_pkg::data_w'(lcg_next()), 1'b0);
  end
  for (int n = 0; n < 2 * (credit_link_pkg::max_credit - 2); n++) begin
    take_word("withhold", got);
  end
  check_drained("withhold");
  apply_reset('0);
endtask

// Hold is pulsed on an empty link and lane 2 then regains its full credit.
task automatic test_link_reset();
  logic [credit_link_pkg::lane_w-1:0] got;
  for (int n = 0; n < 2; n++) begin
    send_word("link_reset", credit_link_pkg::lane_w'(2),
              credit_link_pkg::data_w'(lcg_next()), 1'b1);
    take_word("link_reset", got);
  end
  @(posedge clk);
  #1 link_hold = 1'b1;
  send_word("link_reset", credit_link_pkg::lane_w'(2),
            credit_link_pkg::data_w'(lcg_next()), 1'b0);
  @(posedge clk);
  #1 link_hold = 1'b0;
  for (int n = 0; n < credit_link_pkg::max_credit; n++) begin
    send_word("link_reset", credit_link_pkg::lane_w'(2),
              credit_link_pkg::data_w'(lcg_next()), 1'b1);
  end
  send_word("link_reset", credit_link_pkg::lane_w'(2),
            credit_link_pkg::data_w'(lcg_next()), 1'b0);
  for (int n = 0; n < credit_link_pkg::max_credit; n++) begin
    take_word("link_reset", got);
  end
  check_drained("link_reset");
endtask

// Lane 0 is loaded first while the other lanes are still empty.
// It wins the first grant and the full lanes then follow in index order.
task automatic test_round_robin();
  logic [credit_link_pkg::lane_w-1:0] got;
  for (int n = 0; n < credit_link_pkg::max_credit; n++) begin
    for (int l = 0; l < credit_link_pkg::num_lanes; l++) begin
      send_word("round_robin", credit_link_pkg::lane_w'(l),
                credit_link_pkg::data_w'(lcg_next()), 1'b1);
    end
  end
  for (int n = 0; n < credit_link_pkg::num_lanes * credit_link_pkg::max_credit; n++) begin
    take_word("round_robin", got);
    check_value("round_robin", "out_lane",
                32'(n % credit_link_pkg::num_lanes), 32'(got));
  end
  check_drained("round_robin");
endtask

/* verification/tb_credit_link.sv */
/*
  Directed testbench for credit_link_top.
  Expected words wait in one queue per lane and are checked at the egress.
  Every handshake wait gives up after a fixed number of cycles.
*/

module tb_credit_link;

  // Cycles allowed for the DUT to answer a handshake phase.
  localparam int ack_timeout = 24;
  localparam int req_timeout = 64;

  logic                               clk;
  logic                               rst_n;
  logic [credit_link_pkg::cnt_w-1:0]  credit_withhold;
  logic                               link_hold;
  logic                               in_req;
  logic                               in_ack;
  logic [credit_link_pkg::lane_w-1:0] in_lane;
  logic [credit_link_pkg::data_w-1:0] in_data;
  logic                               out_req;
  logic                               out_ack;
  logic [credit_link_pkg::lane_w-1:0] out_lane;
  logic [credit_link_pkg::data_w-1:0] out_data;

  // Words accepted at the ingress and not yet seen at the egress.
  logic [credit_link_pkg::data_w-1:0] exp_q [credit_link_pkg::num_lanes][$];

  int check_count;
  int error_count;
  int timeout_count;

  // State of the pseudo random generator.
  logic [31:0] rng_state;

  always #4 clk = ~clk;

  credit_link_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .credit_withhold (credit_withhold),
    .link_hold       (link_hold),
    .in_req          (in_req),
    .in_ack          (in_ack),
    .in_lane         (in_lane),
    .in_data         (in_data),
    .out_req         (out_req),
    .out_ack         (out_ack),
    .out_lane        (out_lane),
    .out_data        (out_data)
  );

  // ------------------------------------------------------------
  // Common helpers
  // ------------------------------------------------------------

  // Linear congruential step with a full 32-bit period.
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    assert (expected == actual) else begin
      error_count++;
      $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
    end
  endtask

  // The withhold is set while rst_n is low, before any credit leaves a receiver.
  task automatic apply_reset(input logic [credit_link_pkg::cnt_w-1:0] withhold);
    rst_n           = 1'b0;
    credit_withhold = withhold;
    link_hold       = 1'b0;
    in_req          = 1'b0;
    out_ack         = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < credit_link_pkg::num_lanes; i++) begin
      exp_q[i].delete();
    end
  endtask

  `include "tb_credit_link_tasks.svh"

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    credit_withhold = '0;
    link_hold       = 1'b0;
    in_req          = 1'b0;
    in_lane         = '0;
    in_data         = '0;
    out_ack         = 1'b0;
    rng_state       = 32'h3d3b;
    check_count     = 0;
    error_count     = 0;
    timeout_count   = 0;

    apply_reset('0);
    test_integrity();
    test_backpressure();
    test_withhold();
    test_link_reset();
    test_round_robin();

    $display("Checks: %0d, value errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+verification
hw/credit_link_pkg.sv
hw/credit_sender.sv
hw/credit_receiver.sv
hw/credit_lane.sv
hw/egress_arbiter.sv
hw/credit_link_top.sv
verification/tb_credit_link.sv

/* Makefile */
# Verilator build and run for the credit link testbench.
# Any variable below can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= tb_credit_link
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# The run passes only when the log holds the pass line.
run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
